// File: sim.f
+incdir+include
source/cpuPkg.sv
source/dataMemBus.sv
source/aluUnit.sv
source/registerFile.sv
source/instrDecoder.sv
source/instrMemory.sv
source/dataMemory.sv
source/cpuCore.sv
source/processorTop.sv
bench/processorTb.sv

// File: Bender.yml
package:
  name: processor16

export_include_dirs:
  - include

sources:
  - source/cpuPkg.sv
  - source/dataMemBus.sv
  - source/aluUnit.sv
  - source/registerFile.sv
  - source/instrDecoder.sv
  - source/instrMemory.sv
  - source/dataMemory.sv
  - source/cpuCore.sv
  - source/processorTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/processorTb.sv

// File: include/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Architectural state of the model
cpuPkg::word_t mRegs [16];
cpuPkg::word_t mImem [256];
cpuPkg::word_t mDmem [256];
cpuPkg::word_t mPc;
logic mCarry;
logic mZero;
logic mHalted;

// Retire report expected for the last stepped instruction
cpuPkg::word_t expPc;
logic expRegWe;
cpuPkg::regIdx_t expRegWIdx;
cpuPkg::word_t expRegWData;
logic expMemWe;
cpuPkg::word_t expMemAddr;
cpuPkg::word_t expMemWData;

// Core reset, data memory survives like the DUT's
function automatic void modelReset();
	foreach (mRegs[i]) mRegs[i] = 16'd0;
	mPc = 16'd0;
	mCarry = 1'b0;
	mZero = 1'b0;
	mHalted = 1'b0;
endfunction

// Once at start, mirrors the zeroed data memory
function automatic void modelInit();
	foreach (mDmem[i]) mDmem[i] = 16'd0;
	foreach (mImem[i]) mImem[i] = 16'd0;
	modelReset();
endfunction

function automatic void modelLoad(input cpuPkg::word_t addr, input cpuPkg::word_t data);
	mImem[addr[7:0]] = data;
endfunction

function automatic void modelStep();
	cpuPkg::word_t instr, dv, sv, immW, nextPc;
	cpuPkg::opcode_t op;
	cpuPkg::regIdx_t d, s;
	logic [16:0] wide;
	logic setFlags;
	instr = mImem[mPc[7:0]];
	op = instr[15:12];
	d = instr[11:8];
	s = instr[7:4];
	dv = mRegs[d];
	sv = mRegs[s];
	immW = {8'h00, instr[7:0]};
	expPc = mPc;
	expRegWe = 1'b0;
	expRegWIdx = d;
	expRegWData = 16'd0;
	expMemWe = 1'b0;
	expMemAddr = dv;
	expMemWData = sv;
	wide = 17'd0;
	setFlags = 1'b0;
	nextPc = mPc + 16'd1;
	case (op)
		cpuPkg::OP_ADD: wide = {1'b0, dv} + {1'b0, sv};
		cpuPkg::OP_SUB, cpuPkg::OP_CMP: wide = {1'b0, dv} - {1'b0, sv};
		cpuPkg::OP_AND: wide = {1'b0, dv & sv};
		cpuPkg::OP_OR: wide = {1'b0, dv | sv};
		cpuPkg::OP_XOR: wide = {1'b0, dv ^ sv};
		cpuPkg::OP_SHL: wide = {dv, 1'b0};
		cpuPkg::OP_LDI: expRegWData = immW;
		cpuPkg::OP_LD: expRegWData = mDmem[sv[7:0]];
		cpuPkg::OP_ST: expMemWe = 1'b1;
		cpuPkg::OP_JMP: nextPc = immW;
		cpuPkg::OP_JZ: if (mZero) nextPc = immW;
		cpuPkg::OP_JC: if (mCarry) nextPc = immW;
		cpuPkg::OP_JR: nextPc = sv;
		cpuPkg::OP_HALT: mHalted = 1'b1;
		default: ;
	endcase
	setFlags = (op inside {[cpuPkg::OP_ADD:cpuPkg::OP_SHL], cpuPkg::OP_CMP});
	expRegWe = (op inside {[cpuPkg::OP_ADD:cpuPkg::OP_LD]});
	if (setFlags) begin
		mCarry = wide[16];
		mZero = (wide[15:0] == 16'd0);
		expRegWData = wide[15:0];
	end
	if (expRegWe) mRegs[d] = expRegWData;
	if (expMemWe) mDmem[dv[7:0]] = sv;
	mPc = nextPc;
endfunction

`endif

// File: bench/processorTb.sv
`timescale 1ns/1ps

module processorTb;

	`include "isaModel.svh"

	localparam int numPrograms = 8;
	localparam int progWords = 64;
	localparam int maxRetire = 150;
	localparam int haltWait = 20;
	localparam int resetCycles = 3;
	localparam int imemWords = 256;
	// One clearing pass, then each program at three cycles per retirement at most
	localparam int cycleLimit = imemWords + resetCycles +
		numPrograms * (resetCycles + progWords + maxRetire * 3 + haltWait + 10);

	logic clk;
	logic rst;
	logic run;
	logic loadEn;
	cpuPkg::word_t loadAddr;
	cpuPkg::word_t loadData;
	logic retireValid;
	cpuPkg::word_t retirePc;
	logic regWe;
	cpuPkg::regIdx_t regWIdx;
	cpuPkg::word_t regWData;
	logic memWe;
	cpuPkg::word_t memAddr;
	cpuPkg::word_t memWData;
	logic halted;

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	int cycleCount = 0;

	processorTop #(.imemAddrBits(8), .dmemAddrBits(8)) processorTop_i (
		.clk(clk), .rst(rst), .run(run),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.retireValid(retireValid), .retirePc(retirePc),
		.regWe(regWe), .regWIdx(regWIdx), .regWData(regWData),
		.memWe(memWe), .memAddr(memAddr), .memWData(memWData), .halted(halted)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("run did not finish before the cycle limit");
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic checkWord(input cpuPkg::word_t actual, input cpuPkg::word_t expected,
		input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkIdx(input cpuPkg::regIdx_t actual, input cpuPkg::regIdx_t expected,
		input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkBit(input logic actual, input logic expected, input string name);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	// Nothing may retire or write while the core waits for run
	task automatic checkQuiet();
		checkBit(retireValid, 1'b0, "retireValid");
		checkBit(regWe, 1'b0, "regWe");
		checkBit(memWe, 1'b0, "memWe");
		checkBit(halted, 1'b0, "halted");
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		run <= 1'b0;
		loadEn <= 1'b0;
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic loadWord(input cpuPkg::word_t addr, input cpuPkg::word_t data);
		@(posedge clk);
		loadEn <= 1'b1;
		loadAddr <= addr;
		loadData <= data;
		modelLoad(addr, data);
		@(negedge clk);
		checkQuiet();
	endtask

	// Jump targets kept inside the loaded program, rare HALT
	function automatic cpuPkg::word_t randomInstr();
		cpuPkg::opcode_t op;
		cpuPkg::regIdx_t dst;
		cpuPkg::imm_t low;
		if ($urandom % 48 == 0) op = cpuPkg::OP_HALT;
		else op = 4'($urandom % 15);
		dst = 4'($urandom);
		low = 8'($urandom);
		if (op == cpuPkg::OP_JMP || op == cpuPkg::OP_JZ || op == cpuPkg::OP_JC)
			low = 8'($urandom % progWords);
		return {op, dst, low};
	endfunction

	task automatic checkRetire();
		modelStep();
		checkWord(retirePc, expPc, "retirePc");
		checkBit(regWe, expRegWe, "regWe");
		if (expRegWe) begin
			checkIdx(regWIdx, expRegWIdx, "regWIdx");
			checkWord(regWData, expRegWData, "regWData");
		end
		checkBit(memWe, expMemWe, "memWe");
		if (expMemWe) begin
			checkWord(memAddr, expMemAddr, "memAddr");
			checkWord(memWData, expMemWData, "memWData");
		end
	endtask

	task automatic runProgram(input int progNum);
		int retired;
		int errorsBefore;
		bit done;
		errorsBefore = errorCount;
		retired = 0;
		done = 1'b0;
		applyReset();
		modelReset();
		for (int i = 0; i < progWords; i++) begin
			loadWord(16'(i), randomInstr());
		end
		@(posedge clk);
		loadEn <= 1'b0;
		run <= 1'b1;
		while (!done) begin
			@(negedge clk);
			if (memWe && !retireValid) begin
				$display("Memory write without a store retiring at %0t", $time);
				errorCount++;
			end
			if (retireValid) begin
				checkBit(halted, 1'b0, "halted");
				checkRetire();
				retired++;
				if (mHalted || retired >= maxRetire) done = 1'b1;
			end
		end
		if (mHalted) begin
			@(negedge clk);
			checkBit(halted, 1'b1, "halted");
			repeat (haltWait) begin
				@(negedge clk);
				if (retireValid) begin
					$display("Instruction retired after HALT at %0t", $time);
					errorCount++;
				end
			end
		end
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("Program %0d: %0d retirements, ok", progNum, retired);
		end else begin
			failCount++;
			$display("Program %0d: %0d retirements, failed", progNum, retired);
		end
	endtask

	initial begin
		int seedValue;
		clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = 16'd0;
		loadData = 16'd0;
		seedValue = $urandom(3243);
		modelInit();
		applyReset();
		// Whole instruction memory to LDI words built from their own address
		for (int i = 0; i < imemWords; i++) begin
			loadWord(16'(i), {cpuPkg::OP_LDI, 4'(i), 8'(i)});
		end
		for (int p = 0; p < numPrograms; p++) begin
			runProgram(p);
		end
		$display("Programs passed: %0d, failed: %0d", passCount, failCount);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: source/processorTop.sv
`timescale 1ns/1ps

module processorTop #(
	parameter int imemAddrBits = 8,
	parameter int dmemAddrBits = 8
) (
	input logic clk,
	input logic rst,
	input logic run,
	input logic loadEn,
	input cpuPkg::word_t loadAddr,
	input cpuPkg::word_t loadData,
	output logic retireValid,
	output cpuPkg::word_t retirePc,
	output logic regWe,
	output cpuPkg::regIdx_t regWIdx,
	output cpuPkg::word_t regWData,
	output logic memWe,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWData,
	output logic halted
);

	cpuPkg::word_t fetchAddr;
	cpuPkg::word_t fetchData;

	dataMemBus dmemBus ();

	cpuCore cpuCore_i (
		.clk(clk), .rst(rst), .run(run),
		.fetchAddr(fetchAddr), .fetchData(fetchData), .dmem(dmemBus),
		.retireValid(retireValid), .retirePc(retirePc),
		.regWe(regWe), .regWIdx(regWIdx), .regWData(regWData), .halted(halted)
	);

	instrMemory #(.addrBits(imemAddrBits)) instrMemory_i (
		.clk(clk), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
		.fetchAddr(fetchAddr), .fetchData(fetchData)
	);

	dataMemory #(.addrBits(dmemAddrBits)) dataMemory_i (
		.clk(clk),
		.bus(dmemBus)
	);

	// Store traffic brought out for observation
	assign memWe = dmemBus.we;
	assign memAddr = dmemBus.addr;
	assign memWData = dmemBus.wdata;

endmodule

// File: source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
	input logic clk,
	input logic rst,
	input logic run,
	output cpuPkg::word_t fetchAddr,
	input cpuPkg::word_t fetchData,
	dataMemBus.master dmem,
	output logic retireValid,
	output cpuPkg::word_t retirePc,
	output logic regWe,
	output cpuPkg::regIdx_t regWIdx,
	output cpuPkg::word_t regWData,
	output logic halted
);

	cpuPkg::cpuState_t state;
	cpuPkg::word_t pc, ir, nextPc, immWord;
	cpuPkg::word_t dstData, srcData, aluResult;
	cpuPkg::opcode_t opcode;
	cpuPkg::regIdx_t dstIdx, srcIdx;
	cpuPkg::imm_t imm;
	cpuPkg::wbSel_t wbSel;
	cpuPkg::pcSel_t pcSel;
	logic decRegWe, decFlagWe, isStore, isHalt, inExec, cFlag, zFlag;

	instrDecoder instrDecoder_i (
		.instr(ir), .cFlag(cFlag), .zFlag(zFlag),
		.opcode(opcode), .dstIdx(dstIdx), .srcIdx(srcIdx), .imm(imm),
		.regWe(decRegWe), .flagWe(decFlagWe), .wbSel(wbSel),
		.isStore(isStore), .pcSel(pcSel), .isHalt(isHalt)
	);

	registerFile registerFile_i (
		.clk(clk), .rst(rst), .we(regWe), .dstIdx(dstIdx), .srcIdx(srcIdx),
		.wData(regWData), .dstData(dstData), .srcData(srcData)
	);

	aluUnit aluUnit_i (
		.clk(clk), .rst(rst), .op(opcode), .in1(dstData), .in2(srcData),
		.flagWe(decFlagWe & inExec), .result(aluResult), .cFlag(cFlag), .zFlag(zFlag)
	);

	assign inExec = (state == cpuPkg::S_EXEC);
	assign immWord = {8'h00, imm};

	always_comb begin
		case (pcSel)
			cpuPkg::PC_IMM: nextPc = immWord;
			cpuPkg::PC_REG: nextPc = srcData;
			default: nextPc = pc + 16'd1;
		endcase
		case (wbSel)
			cpuPkg::WB_IMM: regWData = immWord;
			cpuPkg::WB_MEM: regWData = dmem.rdata;
			default: regWData = aluResult;
		endcase
	end

	// Stores address through the destination register, loads through the source
	assign dmem.addr = isStore ? dstData : srcData;
	assign dmem.wdata = srcData;
	assign dmem.we = (state == cpuPkg::S_WBACK);

	assign retireValid = (inExec && !isStore) || (state == cpuPkg::S_WBACK);
	assign retirePc = pc;
	assign regWe = inExec && decRegWe;
	assign regWIdx = dstIdx;
	assign halted = (state == cpuPkg::S_HALT);
	assign fetchAddr = pc;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= cpuPkg::S_IDLE;
			ir <= 16'd0;
		end else begin
			case (state)
				cpuPkg::S_IDLE: if (run) state <= cpuPkg::S_FETCH;
				cpuPkg::S_FETCH: begin
					ir <= fetchData;
					state <= cpuPkg::S_EXEC;
				end
				cpuPkg::S_EXEC: begin
					if (isHalt) state <= cpuPkg::S_HALT;
					else if (isStore) state <= cpuPkg::S_WBACK;
					else state <= cpuPkg::S_FETCH;
				end
				cpuPkg::S_WBACK: state <= cpuPkg::S_FETCH;
				default: state <= cpuPkg::S_HALT;
			endcase
		end
	end

	// PC moves on with every retirement
	always_ff @(posedge clk, posedge rst) begin
		if (rst) pc <= 16'd0;
		else if (retireValid) pc <= nextPc;
	end

	noRetireIdle: assert property (@(posedge clk) disable iff (rst)
		(state == cpuPkg::S_IDLE || state == cpuPkg::S_HALT) |-> !retireValid);
	memWriteInWback: assert property (@(posedge clk) disable iff (rst)
		dmem.we |-> (state == cpuPkg::S_WBACK && isStore));

endmodule

// File: source/dataMemory.sv
`timescale 1ns/1ps

module dataMemory #(
	parameter int addrBits = 8
) (
	input logic clk,
	dataMemBus.slave bus
);

	localparam int depth = 1 << addrBits;

	cpuPkg::word_t mem [depth];

	// Power-up contents are zero, kept across core resets
	initial begin
		for (int i = 0; i < depth; i++) begin
			mem[i] = 16'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.we) begin
			mem[bus.addr[addrBits-1:0]] <= bus.wdata;
		end
	end

	assign bus.rdata = mem[bus.addr[addrBits-1:0]];

	addrKnownOnWrite: assert property (@(posedge clk) bus.we |-> !$isunknown(bus.addr));

endmodule

// File: source/instrMemory.sv
`timescale 1ns/1ps

module instrMemory #(
	parameter int addrBits = 8
) (
	input logic clk,
	input logic loadEn,
	input cpuPkg::word_t loadAddr,
	input cpuPkg::word_t loadData,
	input cpuPkg::word_t fetchAddr,
	output cpuPkg::word_t fetchData
);

	localparam int depth = 1 << addrBits;

	cpuPkg::word_t mem [depth];

	// Program load while the core sits idle
	always_ff @(posedge clk) begin
		if (loadEn) begin
			mem[loadAddr[addrBits-1:0]] <= loadData;
		end
	end

	// Upper address bits ignored
	assign fetchData = mem[fetchAddr[addrBits-1:0]];

endmodule

// File: source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input cpuPkg::word_t instr,
	input logic cFlag,
	input logic zFlag,
	output cpuPkg::opcode_t opcode,
	output cpuPkg::regIdx_t dstIdx,
	output cpuPkg::regIdx_t srcIdx,
	output cpuPkg::imm_t imm,
	output logic regWe,
	output logic flagWe,
	output cpuPkg::wbSel_t wbSel,
	output logic isStore,
	output cpuPkg::pcSel_t pcSel,
	output logic isHalt
);

	// Source index and immediate share the low byte
	assign opcode = instr[15:12];
	assign dstIdx = instr[11:8];
	assign srcIdx = instr[7:4];
	assign imm = instr[7:0];

	always_comb begin
		regWe = 1'b0;
		flagWe = 1'b0;
		wbSel = cpuPkg::WB_ALU;
		isStore = 1'b0;
		pcSel = cpuPkg::PC_INC;
		isHalt = 1'b0;
		case (opcode)
			cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
			cpuPkg::OP_OR, cpuPkg::OP_XOR, cpuPkg::OP_SHL: begin
				regWe = 1'b1;
				flagWe = 1'b1;
			end
			cpuPkg::OP_CMP: flagWe = 1'b1;
			cpuPkg::OP_LDI: begin
				regWe = 1'b1;
				wbSel = cpuPkg::WB_IMM;
			end
			cpuPkg::OP_LD: begin
				regWe = 1'b1;
				wbSel = cpuPkg::WB_MEM;
			end
			cpuPkg::OP_ST: isStore = 1'b1;
			cpuPkg::OP_JMP: pcSel = cpuPkg::PC_IMM;
			// Conditional jumps resolved here from the stored flags
			cpuPkg::OP_JZ: pcSel = zFlag ? cpuPkg::PC_IMM : cpuPkg::PC_INC;
			cpuPkg::OP_JC: pcSel = cFlag ? cpuPkg::PC_IMM : cpuPkg::PC_INC;
			cpuPkg::OP_JR: pcSel = cpuPkg::PC_REG;
			cpuPkg::OP_HALT: isHalt = 1'b1;
			default: begin
			end
		endcase
	end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic rst,
	input logic we,
	input cpuPkg::regIdx_t dstIdx,
	input cpuPkg::regIdx_t srcIdx,
	input cpuPkg::word_t wData,
	output cpuPkg::word_t dstData,
	output cpuPkg::word_t srcData
);

	cpuPkg::word_t regs [16];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'd0;
			end
		end else if (we) begin
			regs[dstIdx] <= wData;
		end
	end

	// Both reads are combinational
	assign dstData = regs[dstIdx];
	assign srcData = regs[srcIdx];

	// A write must never take an unknown value from the write-back path
	wDataKnown: assert property (
		@(posedge clk) disable iff (rst) we |-> !$isunknown(wData)
	);

endmodule

// File: source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input logic clk,
	input logic rst,
	input cpuPkg::opcode_t op,
	input cpuPkg::word_t in1,
	input cpuPkg::word_t in2,
	input logic flagWe,
	output cpuPkg::word_t result,
	output logic cFlag,
	output logic zFlag
);

	// Bit 16 holds carry out, or borrow for subtraction
	logic [16:0] wide;
	logic nextZero;

	always_comb begin
		case (op)
			cpuPkg::OP_ADD: begin
				wide = {1'b0, in1} + {1'b0, in2};
			end
			cpuPkg::OP_SUB,
			cpuPkg::OP_CMP: begin
				wide = {1'b0, in1} - {1'b0, in2};
			end
			cpuPkg::OP_AND: begin
				wide = {1'b0, in1 & in2};
			end
			cpuPkg::OP_OR: begin
				wide = {1'b0, in1 | in2};
			end
			cpuPkg::OP_XOR: begin
				wide = {1'b0, in1 ^ in2};
			end
			// Carry takes the bit shifted out
			cpuPkg::OP_SHL: begin
				wide = {in1, 1'b0};
			end
			default: begin
				wide = {1'b0, in1};
			end
		endcase
	end

	assign result = wide[15:0];
	assign nextZero = (wide[15:0] == 16'd0);

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			cFlag <= 1'b0;
			zFlag <= 1'b0;
		end else if (flagWe) begin
			cFlag <= wide[16];
			zFlag <= nextZero;
		end
	end

endmodule

// File: source/dataMemBus.sv
`timescale 1ns/1ps

interface dataMemBus;

	logic we;
	cpuPkg::word_t addr;
	cpuPkg::word_t wdata;
	// Word at addr, valid in the same cycle
	cpuPkg::word_t rdata;

	modport master (
		output we, addr, wdata,
		input rdata
	);

	modport slave (
		input we, addr, wdata,
		output rdata
	);

endinterface

// File: source/cpuPkg.sv
package cpuPkg;

	// Data word, program counter and instruction word
	typedef logic [15:0] word_t;
	typedef logic [3:0] regIdx_t;
	typedef logic [3:0] opcode_t;
	// Immediate field, zero-extended on use
	typedef logic [7:0] imm_t;

	// Write-back source and next PC source
	typedef logic [1:0] wbSel_t;
	typedef logic [1:0] pcSel_t;

	localparam opcode_t OP_NOP  = 4'd0;
	localparam opcode_t OP_ADD  = 4'd1;
	localparam opcode_t OP_SUB  = 4'd2;
	localparam opcode_t OP_AND  = 4'd3;
	localparam opcode_t OP_OR   = 4'd4;
	localparam opcode_t OP_XOR  = 4'd5;
	localparam opcode_t OP_SHL  = 4'd6;
	localparam opcode_t OP_LDI  = 4'd7;
	localparam opcode_t OP_LD   = 4'd8;
	localparam opcode_t OP_ST   = 4'd9;
	localparam opcode_t OP_JMP  = 4'd10;
	localparam opcode_t OP_JZ   = 4'd11;
	localparam opcode_t OP_JC   = 4'd12;
	localparam opcode_t OP_JR   = 4'd13;
	localparam opcode_t OP_CMP  = 4'd14;
	localparam opcode_t OP_HALT = 4'd15;

	localparam wbSel_t WB_ALU = 2'd0;
	localparam wbSel_t WB_IMM = 2'd1;
	localparam wbSel_t WB_MEM = 2'd2;

	localparam pcSel_t PC_INC = 2'd0;
	localparam pcSel_t PC_IMM = 2'd1;
	localparam pcSel_t PC_REG = 2'd2;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_WBACK,
		S_HALT
	} cpuState_t;

endpackage
